// File: logic/decode_pkg.sv
package decode_pkg;

	localparam int INSTR_W = 32;
	localparam int OP_W = 6;
	localparam int FUNCT_W = 6;
	localparam int REG_W = 5;

	// primary opcode field, instr[31:26]
	typedef enum logic [OP_W-1:0] {
		R_TYPE   = 6'h00,
		REGIMM   = 6'h01,
		J        = 6'h02,
		JAL      = 6'h03,
		BEQ      = 6'h04,
		BNE      = 6'h05,
		BLEZ     = 6'h06,
		BGTZ     = 6'h07,
		ADDI     = 6'h08,
		ADDIU    = 6'h09,
		SLTI     = 6'h0a,
		SLTIU    = 6'h0b,
		ANDI     = 6'h0c,
		ORI      = 6'h0d,
		XORI     = 6'h0e,
		LUI      = 6'h0f,
		COP0     = 6'h10,
		SPECIAL2 = 6'h1c,
		LB       = 6'h20,
		LH       = 6'h21,
		LWL      = 6'h22,
		LW       = 6'h23,
		LBU      = 6'h24,
		LHU      = 6'h25,
		LWR      = 6'h26,
		SB       = 6'h28,
		SH       = 6'h29,
		SWL      = 6'h2a,
		SW       = 6'h2b,
		SWR      = 6'h2e,
		LL       = 6'h30
	} opcode_e;

	typedef enum logic [FUNCT_W-1:0] {
		SLL = 6'h00, SRL = 6'h02, SRA = 6'h03, SLLV = 6'h04, SRLV = 6'h06, SRAV = 6'h07,
		JR = 6'h08, JALR = 6'h09, MOVZ = 6'h0a, MOVN = 6'h0b, SYSCALL = 6'h0c, BREAK = 6'h0d,
		MFHI = 6'h10, MTHI = 6'h11, MFLO = 6'h12, MTLO = 6'h13,
		MULT = 6'h18, MULTU = 6'h19, DIV = 6'h1a, DIVU = 6'h1b,
		ADD = 6'h20, ADDU = 6'h21, SUB = 6'h22, SUBU = 6'h23,
		AND = 6'h24, OR = 6'h25, XOR = 6'h26, NOR = 6'h27, SLT = 6'h2a, SLTU = 6'h2b,
		TGE = 6'h30, TGEU = 6'h31, TLT = 6'h32, TLTU = 6'h33, TEQ = 6'h34, TNE = 6'h36
	} funct_e;

	// SPECIAL2 functs overlap the R-type codes, so they get their own type
	typedef enum logic [FUNCT_W-1:0] {
		MADD = 6'h00, MADDU = 6'h01, MUL = 6'h02, MSUB = 6'h04, MSUBU = 6'h05
	} special2_e;

	// rt subcode under REGIMM
	typedef enum logic [REG_W-1:0] {
		BLTZ = 5'h00, BGEZ = 5'h01, TGEI = 5'h08, TGEIU = 5'h09, TLTI = 5'h0a,
		TLTIU = 5'h0b, TEQI = 5'h0c, TNEI = 5'h0e, BLTZAL = 5'h10, BGEZAL = 5'h11
	} regimm_e;

	// rs subcode under COP0
	typedef enum logic [REG_W-1:0] {
		MFC0 = 5'h00, MTC0 = 5'h04, CO = 5'h10
	} cop0_e;

	localparam logic [INSTR_W-OP_W-1:0] ERET_WORD = 26'h2000018;

	typedef enum logic [4:0] {
		ALU_R_TYPE, ALU_ROTR, ALU_ROTRV,
		ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU, ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LUI,
		ALU_MEM, ALU_MTC0, ALU_MFC0,
		ALU_TEQI, ALU_TGEI, ALU_TGEIU, ALU_TLTI, ALU_TLTIU, ALU_TNEI,
		ALU_MUL, ALU_MADD, ALU_MADDU, ALU_MSUB, ALU_MSUBU,
		ALU_NONE
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0, BR_EQ = 3'd1, BR_NE = 3'd2, BR_LEZ = 3'd3,
		BR_GTZ = 3'd4, BR_LTZ = 3'd5, BR_GEZ = 3'd6
	} branch_cond_e;

	typedef enum logic [1:0] {
		DEST_RD = 2'd0, DEST_RT = 2'd1, DEST_R31 = 2'd2
	} dest_sel_e;

endpackage

// File: logic/class_decoder.sv
`timescale 1ns/10ps

module class_decoder (
	input logic [decode_pkg::INSTR_W-1:0] instr,
	output logic reg_write,
	output logic is_imm,
	output logic mem_to_reg,
	output logic mem_read,
	output logic mem_write,
	output logic reserved_instr,
	output logic is_mfc,
	output logic only_one_issue,
	output decode_pkg::dest_sel_e dest_sel,
	output decode_pkg::alu_op_e alu_op
);

	decode_pkg::opcode_e op;
	decode_pkg::funct_e funct;
	decode_pkg::special2_e sp2_funct;
	decode_pkg::regimm_e rt_code;
	decode_pkg::cop0_e rs_code;

	assign op = decode_pkg::opcode_e'(instr[decode_pkg::INSTR_W-1 -: decode_pkg::OP_W]);
	assign funct = decode_pkg::funct_e'(instr[decode_pkg::FUNCT_W-1:0]);
	assign sp2_funct = decode_pkg::special2_e'(instr[decode_pkg::FUNCT_W-1:0]);
	assign rt_code = decode_pkg::regimm_e'(instr[20:16]);
	assign rs_code = decode_pkg::cop0_e'(instr[25:21]);

	function automatic decode_pkg::alu_op_e imm_alu(input decode_pkg::opcode_e code);
		case (code)
			decode_pkg::ADDI:  return decode_pkg::ALU_ADDI;
			decode_pkg::ADDIU: return decode_pkg::ALU_ADDIU;
			decode_pkg::SLTI:  return decode_pkg::ALU_SLTI;
			decode_pkg::SLTIU: return decode_pkg::ALU_SLTIU;
			decode_pkg::ANDI:  return decode_pkg::ALU_ANDI;
			decode_pkg::ORI:   return decode_pkg::ALU_ORI;
			decode_pkg::XORI:  return decode_pkg::ALU_XORI;
			decode_pkg::LUI:   return decode_pkg::ALU_LUI;
			default:           return decode_pkg::ALU_NONE;
		endcase
	endfunction

	always_comb begin
		reg_write = 1'b0;
		is_imm = 1'b0;
		mem_to_reg = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reserved_instr = 1'b0;
		is_mfc = 1'b0;
		only_one_issue = 1'b0;
		dest_sel = decode_pkg::DEST_RD;
		alu_op = decode_pkg::ALU_NONE;
		case (op)
			decode_pkg::R_TYPE: begin
				// unknown functs still write rd
				reg_write = 1'b1;
				case (funct)
					decode_pkg::ADD, decode_pkg::ADDU, decode_pkg::SUB, decode_pkg::SUBU,
					decode_pkg::SLT, decode_pkg::SLTU, decode_pkg::AND, decode_pkg::OR,
					decode_pkg::XOR, decode_pkg::NOR, decode_pkg::SLL, decode_pkg::SLLV,
					decode_pkg::SRA, decode_pkg::SRAV, decode_pkg::MOVZ, decode_pkg::MOVN,
					decode_pkg::MFHI, decode_pkg::MFLO:
						alu_op = decode_pkg::ALU_R_TYPE;
					// rs bit 0 selects rotr
					decode_pkg::SRL:
						alu_op = instr[21] ? decode_pkg::ALU_ROTR : decode_pkg::ALU_R_TYPE;
					// sa bit 0 selects rotrv
					decode_pkg::SRLV:
						alu_op = instr[6] ? decode_pkg::ALU_ROTRV : decode_pkg::ALU_R_TYPE;
					decode_pkg::JR, decode_pkg::MULT, decode_pkg::MULTU, decode_pkg::DIV,
					decode_pkg::DIVU, decode_pkg::MTHI, decode_pkg::MTLO, decode_pkg::SYSCALL,
					decode_pkg::BREAK, decode_pkg::TEQ, decode_pkg::TGE, decode_pkg::TGEU,
					decode_pkg::TNE, decode_pkg::TLT, decode_pkg::TLTU: begin
						alu_op = decode_pkg::ALU_R_TYPE;
						reg_write = 1'b0;
					end
					decode_pkg::JALR: begin
						alu_op = decode_pkg::ALU_R_TYPE;
						dest_sel = decode_pkg::DEST_R31;
					end
					default: reserved_instr = 1'b1;
				endcase
			end
			decode_pkg::ADDI, decode_pkg::ADDIU, decode_pkg::SLTI, decode_pkg::SLTIU,
			decode_pkg::ANDI, decode_pkg::ORI, decode_pkg::XORI, decode_pkg::LUI: begin
				reg_write = 1'b1;
				dest_sel = decode_pkg::DEST_RT;
				is_imm = 1'b1;
				alu_op = imm_alu(op);
			end
			decode_pkg::LB, decode_pkg::LH, decode_pkg::LWL, decode_pkg::LW,
			decode_pkg::LBU, decode_pkg::LHU, decode_pkg::LWR, decode_pkg::LL: begin
				reg_write = 1'b1;
				dest_sel = decode_pkg::DEST_RT;
				is_imm = 1'b1;
				mem_to_reg = 1'b1;
				mem_read = 1'b1;
				alu_op = decode_pkg::ALU_MEM;
				only_one_issue = 1'b1;
			end
			decode_pkg::SB, decode_pkg::SH, decode_pkg::SWL, decode_pkg::SW,
			decode_pkg::SWR: begin
				is_imm = 1'b1;
				mem_write = 1'b1;
				alu_op = decode_pkg::ALU_MEM;
				only_one_issue = 1'b1;
			end
			decode_pkg::BEQ, decode_pkg::BNE, decode_pkg::BLEZ, decode_pkg::BGTZ,
			decode_pkg::J: begin
			end
			decode_pkg::JAL: begin
				reg_write = 1'b1;
				dest_sel = decode_pkg::DEST_R31;
			end
			decode_pkg::REGIMM: begin
				case (rt_code)
					decode_pkg::BLTZAL, decode_pkg::BGEZAL: begin
						reg_write = 1'b1;
						dest_sel = decode_pkg::DEST_R31;
					end
					decode_pkg::BLTZ, decode_pkg::BGEZ: begin
					end
					decode_pkg::TEQI:  alu_op = decode_pkg::ALU_TEQI;
					decode_pkg::TGEI:  alu_op = decode_pkg::ALU_TGEI;
					decode_pkg::TGEIU: alu_op = decode_pkg::ALU_TGEIU;
					decode_pkg::TLTI:  alu_op = decode_pkg::ALU_TLTI;
					decode_pkg::TLTIU: alu_op = decode_pkg::ALU_TLTIU;
					decode_pkg::TNEI:  alu_op = decode_pkg::ALU_TNEI;
					default: reserved_instr = 1'b1;
				endcase
			end
			decode_pkg::COP0: begin
				only_one_issue = 1'b1;
				case (rs_code)
					decode_pkg::MTC0: alu_op = decode_pkg::ALU_MTC0;
					decode_pkg::MFC0: begin
						alu_op = decode_pkg::ALU_MFC0;
						is_mfc = 1'b1;
						reg_write = 1'b1;
						dest_sel = decode_pkg::DEST_RT;
					end
					// only eret is legal in the rest of the space
					default: reserved_instr = (instr[25:0] != decode_pkg::ERET_WORD);
				endcase
			end
			decode_pkg::SPECIAL2: begin
				case (sp2_funct)
					decode_pkg::MUL: begin
						alu_op = decode_pkg::ALU_MUL;
						reg_write = 1'b1;
					end
					decode_pkg::MADD:  alu_op = decode_pkg::ALU_MADD;
					decode_pkg::MADDU: alu_op = decode_pkg::ALU_MADDU;
					decode_pkg::MSUB:  alu_op = decode_pkg::ALU_MSUB;
					decode_pkg::MSUBU: alu_op = decode_pkg::ALU_MSUBU;
					default: reserved_instr = 1'b1;
				endcase
			end
			default: reserved_instr = 1'b1;
		endcase
	end

endmodule

// File: logic/branch_decoder.sv
`timescale 1ns/10ps

module branch_decoder (
	input logic [decode_pkg::INSTR_W-1:0] instr,
	output decode_pkg::branch_cond_e branch_cond
);

	decode_pkg::opcode_e op;
	decode_pkg::regimm_e rt_code;

	assign op = decode_pkg::opcode_e'(instr[decode_pkg::INSTR_W-1 -: decode_pkg::OP_W]);
	assign rt_code = decode_pkg::regimm_e'(instr[20:16]);

	always_comb begin
		case (op)
			decode_pkg::BEQ:  branch_cond = decode_pkg::BR_EQ;
			decode_pkg::BNE:  branch_cond = decode_pkg::BR_NE;
			decode_pkg::BLEZ: branch_cond = decode_pkg::BR_LEZ;
			decode_pkg::BGTZ: branch_cond = decode_pkg::BR_GTZ;
			decode_pkg::REGIMM: begin
				case (rt_code)
					decode_pkg::BGEZ, decode_pkg::BGEZAL:
						branch_cond = decode_pkg::BR_GEZ;
					// traps and unknown rt fall onto ltz too
					default:
						branch_cond = decode_pkg::BR_LTZ;
				endcase
			end
			default: branch_cond = decode_pkg::BR_NONE;
		endcase
	end

endmodule

// File: logic/operand_use_decoder.sv
`timescale 1ns/10ps

module operand_use_decoder (
	input logic [decode_pkg::INSTR_W-1:0] instr,
	output logic read_rs,
	output logic read_rt
);

	decode_pkg::opcode_e op;
	decode_pkg::funct_e funct;
	decode_pkg::special2_e sp2_funct;
	decode_pkg::regimm_e rt_code;
	decode_pkg::cop0_e rs_code;

	assign op = decode_pkg::opcode_e'(instr[decode_pkg::INSTR_W-1 -: decode_pkg::OP_W]);
	assign funct = decode_pkg::funct_e'(instr[decode_pkg::FUNCT_W-1:0]);
	assign sp2_funct = decode_pkg::special2_e'(instr[decode_pkg::FUNCT_W-1:0]);
	assign rt_code = decode_pkg::regimm_e'(instr[20:16]);
	assign rs_code = decode_pkg::cop0_e'(instr[25:21]);

	always_comb begin
		read_rs = 1'b0;
		read_rt = 1'b0;
		case (op)
			decode_pkg::R_TYPE: begin
				case (funct)
					decode_pkg::ADD, decode_pkg::ADDU, decode_pkg::SUB, decode_pkg::SUBU,
					decode_pkg::SLT, decode_pkg::SLTU, decode_pkg::AND, decode_pkg::OR,
					decode_pkg::XOR, decode_pkg::NOR, decode_pkg::SLLV, decode_pkg::SRLV,
					decode_pkg::SRAV, decode_pkg::MOVZ, decode_pkg::MOVN, decode_pkg::MULT,
					decode_pkg::MULTU, decode_pkg::DIV, decode_pkg::DIVU, decode_pkg::TEQ,
					decode_pkg::TGE, decode_pkg::TGEU, decode_pkg::TLT, decode_pkg::TLTU,
					decode_pkg::TNE: begin
						read_rs = 1'b1;
						read_rt = 1'b1;
					end
					// constant shifts take sa instead of rs
					decode_pkg::SLL, decode_pkg::SRL, decode_pkg::SRA:
						read_rt = 1'b1;
					decode_pkg::JR, decode_pkg::JALR, decode_pkg::MTHI, decode_pkg::MTLO:
						read_rs = 1'b1;
					// mfhi, mflo, syscall, break and unknown codes
					default: begin
					end
				endcase
			end
			decode_pkg::ADDI, decode_pkg::ADDIU, decode_pkg::SLTI, decode_pkg::SLTIU,
			decode_pkg::ANDI, decode_pkg::ORI, decode_pkg::XORI:
				read_rs = 1'b1;
			decode_pkg::BEQ, decode_pkg::BNE: begin
				read_rs = 1'b1;
				read_rt = 1'b1;
			end
			decode_pkg::BLEZ, decode_pkg::BGTZ:
				read_rs = 1'b1;
			decode_pkg::REGIMM: begin
				case (rt_code)
					decode_pkg::BLTZ, decode_pkg::BGEZ, decode_pkg::BLTZAL, decode_pkg::BGEZAL,
					decode_pkg::TGEI, decode_pkg::TGEIU, decode_pkg::TLTI, decode_pkg::TLTIU,
					decode_pkg::TEQI, decode_pkg::TNEI:
						read_rs = 1'b1;
					default: read_rs = 1'b0;
				endcase
			end
			decode_pkg::SB, decode_pkg::SH, decode_pkg::SWL, decode_pkg::SW,
			decode_pkg::SWR:
				read_rt = 1'b1;
			decode_pkg::COP0:
				read_rt = (rs_code == decode_pkg::MTC0);
			decode_pkg::SPECIAL2: begin
				case (sp2_funct)
					decode_pkg::MUL, decode_pkg::MADD, decode_pkg::MADDU, decode_pkg::MSUB,
					decode_pkg::MSUBU: begin
						read_rs = 1'b1;
						read_rt = 1'b1;
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

endmodule

// File: logic/special_op_decoder.sv
`timescale 1ns/10ps

module special_op_decoder (
	input logic [decode_pkg::INSTR_W-1:0] instr,
	output logic sign_ext,
	output logic cp0_write,
	output logic cp0_read,
	output logic mfhi,
	output logic mflo,
	output logic eret,
	output logic break_exc,
	output logic syscall,
	output logic hilo_read,
	output logic div_mul_en
);

	decode_pkg::opcode_e op;
	decode_pkg::funct_e funct;
	decode_pkg::special2_e sp2_funct;
	decode_pkg::cop0_e rs_code;
	logic is_r;
	logic is_cop0;
	logic is_sp2;

	assign op = decode_pkg::opcode_e'(instr[decode_pkg::INSTR_W-1 -: decode_pkg::OP_W]);
	assign funct = decode_pkg::funct_e'(instr[decode_pkg::FUNCT_W-1:0]);
	assign sp2_funct = decode_pkg::special2_e'(instr[decode_pkg::FUNCT_W-1:0]);
	assign rs_code = decode_pkg::cop0_e'(instr[25:21]);

	assign is_r = (op == decode_pkg::R_TYPE);
	assign is_cop0 = (op == decode_pkg::COP0);
	assign is_sp2 = (op == decode_pkg::SPECIAL2);

	// andi, ori, xori and lui zero-extend
	assign sign_ext = (instr[31:28] != 4'b0011);

	assign mfhi = is_r && (funct == decode_pkg::MFHI);
	assign mflo = is_r && (funct == decode_pkg::MFLO);
	assign hilo_read = mfhi || mflo;
	assign syscall = is_r && (funct == decode_pkg::SYSCALL);
	assign break_exc = is_r && (funct == decode_pkg::BREAK);

	assign cp0_write = is_cop0 && (rs_code == decode_pkg::MTC0);
	assign cp0_read = is_cop0 && (rs_code == decode_pkg::MFC0);
	assign eret = is_cop0 && (rs_code == decode_pkg::CO);

	assign div_mul_en = (is_r && (funct inside {decode_pkg::MULT, decode_pkg::MULTU,
			decode_pkg::DIV, decode_pkg::DIVU})) ||
		(is_sp2 && (sp2_funct inside {decode_pkg::MUL, decode_pkg::MADD, decode_pkg::MADDU,
			decode_pkg::MSUB, decode_pkg::MSUBU}));

endmodule

// File: logic/instr_decode_top.sv
`timescale 1ns/10ps

module instr_decode_top (
	input logic clk,
	input logic rst_n,
	input logic [decode_pkg::INSTR_W-1:0] instr,
	input logic instr_valid,
	output logic dec_valid,
	output logic reg_write,
	output logic is_imm,
	output logic mem_to_reg,
	output logic mem_read,
	output logic mem_write,
	output logic read_rs,
	output logic read_rt,
	output logic sign_ext,
	output logic reserved_instr,
	output logic is_mfc,
	output logic only_one_issue,
	output logic cp0_write,
	output logic cp0_read,
	output logic mfhi,
	output logic mflo,
	output logic eret,
	output logic break_exc,
	output logic syscall,
	output logic hilo_read,
	output logic div_mul_en,
	output decode_pkg::dest_sel_e dest_sel,
	output decode_pkg::alu_op_e alu_op,
	output decode_pkg::branch_cond_e branch_cond
);

	localparam int FLAG_W = 20;

	logic reg_write_d, is_imm_d, mem_to_reg_d, mem_read_d, mem_write_d;
	logic read_rs_d, read_rt_d, sign_ext_d, reserved_d, is_mfc_d, one_issue_d;
	logic cp0_write_d, cp0_read_d, mfhi_d, mflo_d, eret_d, break_d, syscall_d;
	logic hilo_read_d, div_mul_en_d;
	decode_pkg::dest_sel_e dest_sel_d;
	decode_pkg::alu_op_e alu_op_d;
	decode_pkg::branch_cond_e branch_cond_d;
	logic [FLAG_W-1:0] flags_d;
	logic [FLAG_W-1:0] flags_q;

	class_decoder u_class (
		.instr(instr), .reg_write(reg_write_d), .is_imm(is_imm_d),
		.mem_to_reg(mem_to_reg_d), .mem_read(mem_read_d), .mem_write(mem_write_d),
		.reserved_instr(reserved_d), .is_mfc(is_mfc_d), .only_one_issue(one_issue_d),
		.dest_sel(dest_sel_d), .alu_op(alu_op_d)
	);

	branch_decoder u_branch (.instr(instr), .branch_cond(branch_cond_d));

	operand_use_decoder u_operand (.instr(instr), .read_rs(read_rs_d), .read_rt(read_rt_d));

	special_op_decoder u_special (
		.instr(instr), .sign_ext(sign_ext_d), .cp0_write(cp0_write_d), .cp0_read(cp0_read_d),
		.mfhi(mfhi_d), .mflo(mflo_d), .eret(eret_d), .break_exc(break_d),
		.syscall(syscall_d), .hilo_read(hilo_read_d), .div_mul_en(div_mul_en_d)
	);

	assign flags_d = {reg_write_d, is_imm_d, mem_to_reg_d, mem_read_d, mem_write_d,
		read_rs_d, read_rt_d, sign_ext_d, reserved_d, is_mfc_d, one_issue_d,
		cp0_write_d, cp0_read_d, mfhi_d, mflo_d, eret_d, break_d, syscall_d,
		hilo_read_d, div_mul_en_d};

	// decode stage register, a bubble clears the whole control word
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
			flags_q <= '0;
			dest_sel <= decode_pkg::DEST_RD;
			alu_op <= decode_pkg::ALU_R_TYPE;
			branch_cond <= decode_pkg::BR_NONE;
		end else begin
			dec_valid <= instr_valid;
			flags_q <= instr_valid ? flags_d : '0;
			dest_sel <= instr_valid ? dest_sel_d : decode_pkg::DEST_RD;
			alu_op <= instr_valid ? alu_op_d : decode_pkg::ALU_R_TYPE;
			branch_cond <= instr_valid ? branch_cond_d : decode_pkg::BR_NONE;
		end
	end

	assign {reg_write, is_imm, mem_to_reg, mem_read, mem_write,
		read_rs, read_rt, sign_ext, reserved_instr, is_mfc, only_one_issue,
		cp0_write, cp0_read, mfhi, mflo, eret, break_exc, syscall,
		hilo_read, div_mul_en} = flags_q;

endmodule

// File: testbench/decode_sva.sv
`timescale 1ns/10ps

module decode_sva (
	input logic clk,
	input logic rst_n,
	input logic instr_valid,
	input logic dec_valid,
	input logic reg_write,
	input logic mem_read,
	input logic mem_write
);

	mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write are high together");

	// a bubble carries no side effects
	bubble_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!dec_valid |-> !(reg_write || mem_read || mem_write))
		else $error("write or memory control is high while dec_valid is low");

	valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
		dec_valid == $past(instr_valid))
		else $error("dec_valid does not follow instr_valid by one cycle");

endmodule

bind instr_decode_top decode_sva u_sva (
	.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .dec_valid(dec_valid),
	.reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write)
);

// File: testbench/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// columns: instruction word, control flags, dest_sel, alu_op, branch_cond
// flag order, msb first: reg_write is_imm mem_to_reg mem_read | mem_write read_rs read_rt
// sign_ext | reserved_instr is_mfc only_one_issue cp0_write | cp0_read mfhi mflo eret |
// break_exc syscall hilo_read div_mul_en
localparam int NUM_VEC = 38;

localparam logic [61:0] VECTORS [NUM_VEC] = '{
	// R-type
	{32'h00221820, 20'h87000, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	{32'h00021900, 20'h83000, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	{32'h00021902, 20'h83000, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	{32'h00221902, 20'h83000, decode_pkg::DEST_RD, decode_pkg::ALU_ROTR, decode_pkg::BR_NONE},
	{32'h00221806, 20'h87000, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	{32'h00221846, 20'h87000, decode_pkg::DEST_RD, decode_pkg::ALU_ROTRV, decode_pkg::BR_NONE},
	{32'h03e00008, 20'h05000, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	{32'h0080f809, 20'h85000, decode_pkg::DEST_R31, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	{32'h00002810, 20'h81042, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	{32'h00002812, 20'h81022, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	{32'h00220018, 20'h07001, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	// immediates, loads, stores
	{32'h2022ffff, 20'hc5000, decode_pkg::DEST_RT, decode_pkg::ALU_ADDI, decode_pkg::BR_NONE},
	{32'h302200ff, 20'hc4000, decode_pkg::DEST_RT, decode_pkg::ALU_ANDI, decode_pkg::BR_NONE},
	{32'h3c021234, 20'hc0000, decode_pkg::DEST_RT, decode_pkg::ALU_LUI, decode_pkg::BR_NONE},
	{32'h28220010, 20'hc5000, decode_pkg::DEST_RT, decode_pkg::ALU_SLTI, decode_pkg::BR_NONE},
	{32'h8c220004, 20'hf1200, decode_pkg::DEST_RT, decode_pkg::ALU_MEM, decode_pkg::BR_NONE},
	{32'h90220008, 20'hf1200, decode_pkg::DEST_RT, decode_pkg::ALU_MEM, decode_pkg::BR_NONE},
	{32'hac220008, 20'h4b200, decode_pkg::DEST_RD, decode_pkg::ALU_MEM, decode_pkg::BR_NONE},
	{32'ha0220001, 20'h4b200, decode_pkg::DEST_RD, decode_pkg::ALU_MEM, decode_pkg::BR_NONE},
	// branches and jumps
	{32'h10220010, 20'h07000, decode_pkg::DEST_RD, decode_pkg::ALU_NONE, decode_pkg::BR_EQ},
	{32'h18200010, 20'h05000, decode_pkg::DEST_RD, decode_pkg::ALU_NONE, decode_pkg::BR_LEZ},
	{32'h04300010, 20'h85000, decode_pkg::DEST_R31, decode_pkg::ALU_NONE, decode_pkg::BR_LTZ},
	{32'h04210010, 20'h05000, decode_pkg::DEST_RD, decode_pkg::ALU_NONE, decode_pkg::BR_GEZ},
	{32'h08000100, 20'h01000, decode_pkg::DEST_RD, decode_pkg::ALU_NONE, decode_pkg::BR_NONE},
	{32'h0c000100, 20'h81000, decode_pkg::DEST_R31, decode_pkg::ALU_NONE, decode_pkg::BR_NONE},
	// cop0, the last one is a CO word that is not eret
	{32'h40826000, 20'h03300, decode_pkg::DEST_RD, decode_pkg::ALU_MTC0, decode_pkg::BR_NONE},
	{32'h40026000, 20'h81680, decode_pkg::DEST_RT, decode_pkg::ALU_MFC0, decode_pkg::BR_NONE},
	{32'h42000018, 20'h01210, decode_pkg::DEST_RD, decode_pkg::ALU_NONE, decode_pkg::BR_NONE},
	{32'h42000001, 20'h01a10, decode_pkg::DEST_RD, decode_pkg::ALU_NONE, decode_pkg::BR_NONE},
	// special2, traps, syscall, break
	{32'h70221802, 20'h87001, decode_pkg::DEST_RD, decode_pkg::ALU_MUL, decode_pkg::BR_NONE},
	{32'h70220000, 20'h07001, decode_pkg::DEST_RD, decode_pkg::ALU_MADD, decode_pkg::BR_NONE},
	{32'h00220034, 20'h07000, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	{32'h04280005, 20'h05000, decode_pkg::DEST_RD, decode_pkg::ALU_TGEI, decode_pkg::BR_LTZ},
	{32'h0000000c, 20'h01004, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	{32'h0000000d, 20'h01008, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE, decode_pkg::BR_NONE},
	// reserved opcode, R funct, special2 funct
	{32'hfc000000, 20'h01800, decode_pkg::DEST_RD, decode_pkg::ALU_NONE, decode_pkg::BR_NONE},
	{32'h00221801, 20'h81800, decode_pkg::DEST_RD, decode_pkg::ALU_NONE, decode_pkg::BR_NONE},
	{32'h70221820, 20'h01800, decode_pkg::DEST_RD, decode_pkg::ALU_NONE, decode_pkg::BR_NONE}
};

`endif

// File: testbench/decode_tb.sv
`timescale 1ns/10ps

module decode_tb;

	localparam int FLAGS = 20;
	localparam int SEED = 77496;

	`include "decode_vectors.svh"

	// reset plus at most three cycles per entry and some margin
	localparam int TIMEOUT_CYCLES = 10 + 3 * NUM_VEC + 20;

	logic clk;
	logic rst_n;
	logic [decode_pkg::INSTR_W-1:0] instr;
	logic instr_valid;
	logic dec_valid, reg_write, is_imm, mem_to_reg, mem_read, mem_write;
	logic read_rs, read_rt, sign_ext, reserved_instr, is_mfc, only_one_issue;
	logic cp0_write, cp0_read, mfhi, mflo, eret, break_exc, syscall;
	logic hilo_read, div_mul_en;
	decode_pkg::dest_sel_e dest_sel;
	decode_pkg::alu_op_e alu_op;
	decode_pkg::branch_cond_e branch_cond;
	logic [FLAGS-1:0] act_flags;
	int cycles = 0;

	string flag_names [FLAGS] = '{
		"reg_write", "is_imm", "mem_to_reg", "mem_read", "mem_write",
		"read_rs", "read_rt", "sign_ext", "reserved_instr", "is_mfc",
		"only_one_issue", "cp0_write", "cp0_read", "mfhi", "mflo",
		"eret", "break_exc", "syscall", "hilo_read", "div_mul_en"
	};

	assign act_flags = {reg_write, is_imm, mem_to_reg, mem_read, mem_write,
		read_rs, read_rt, sign_ext, reserved_instr, is_mfc, only_one_issue,
		cp0_write, cp0_read, mfhi, mflo, eret, break_exc, syscall,
		hilo_read, div_mul_en};

	instr_decode_top DUT (.*);

	always #5 clk = ~clk;

	task automatic stop_with_failure();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_outputs(input logic valid_exp, input logic [FLAGS-1:0] flags_exp,
		input logic [1:0] dest_exp, input logic [4:0] alu_exp, input logic [2:0] br_exp);
		int i;
		compare_value("dec_valid", valid_exp, dec_valid);
		for (i = 0; i < FLAGS; i++) begin
			compare_value(flag_names[i], flags_exp[FLAGS-1-i], act_flags[FLAGS-1-i]);
		end
		compare_value("dest_sel", dest_exp, dest_sel);
		compare_value("alu_op", alu_exp, alu_op);
		compare_value("branch_cond", br_exp, branch_cond);
	endtask

	// bubble and reset state share one control word
	task automatic check_idle();
		check_outputs(1'b0, '0, decode_pkg::DEST_RD, decode_pkg::ALU_R_TYPE,
			decode_pkg::BR_NONE);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	initial begin
		int n;
		int gap;
		logic [61:0] vec;
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		void'($urandom(SEED));
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		// still reset values before the first edge after release
		@(negedge clk);
		check_idle();
		for (n = 0; n < NUM_VEC; n++) begin
			vec = VECTORS[n];
			gap = $urandom % 2;
			// previous word stays on instr while valid is low
			repeat (gap) begin
				@(posedge clk);
				@(negedge clk);
				check_idle();
			end
			@(posedge clk);
			instr <= vec[61:30];
			instr_valid <= 1'b1;
			@(posedge clk);
			instr_valid <= 1'b0;
			@(negedge clk);
			check_outputs(1'b1, vec[29:10], vec[9:8], vec[7:3], vec[2:0]);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+testbench
logic/decode_pkg.sv
logic/class_decoder.sv
logic/branch_decoder.sv
logic/operand_use_decoder.sv
logic/special_op_decoder.sv
logic/instr_decode_top.sv
testbench/decode_sva.sv
testbench/decode_tb.sv
